//--- source/dbus_pkg.sv
package dbus_pkg;

    // bus geometry
    localparam int NCORES     = 4;
    localparam int CORE_IDW   = $clog2(NCORES);
    localparam int DMEM_ADDRW = 10;                // word address
    localparam int DATAW      = 32;
    localparam int STRBW      = DATAW / 8;         // one strobe per byte
    localparam int DMEM_DEPTH = 2 ** DMEM_ADDRW;

    // issue lane states
    localparam logic [1:0] LANE_IDLE     = 2'd0;
    localparam logic [1:0] LANE_RSVCHECK = 2'd1;
    localparam logic [1:0] LANE_ACCESS   = 2'd2;

    // store-conditional result word
    localparam logic [DATAW-1:0] SC_OK   = 32'd0;
    localparam logic [DATAW-1:0] SC_FAIL = 32'd1;

endpackage

//--- source/pending_if.sv
`timescale 1ns/10ps

interface pending_if
    import dbus_pkg::*;
();
    logic [NCORES-1:0]                 valid;
    logic [NCORES-1:0]                 re;
    logic [NCORES-1:0]                 we;
    logic [NCORES-1:0]                 lr;
    logic [NCORES-1:0]                 sc;
    logic [NCORES-1:0][DMEM_ADDRW-1:0] addr;
    logic [NCORES-1:0][DATAW-1:0]      wdata;
    logic [NCORES-1:0][STRBW-1:0]      wstrb;
    logic                              served;       // slot done this cycle
    logic [CORE_IDW-1:0]               served_core;

    modport capture (
        output valid, re, we, lr, sc, addr, wdata, wstrb,
        input  served, served_core
    );

    modport lane (
        input  valid, re, we, lr, sc, addr, wdata, wstrb,
        output served, served_core
    );

endinterface

//--- source/mem_port_if.sv
`timescale 1ns/10ps

interface mem_port_if
    import dbus_pkg::*;
();
    logic                  re;
    logic                  we;
    logic [DMEM_ADDRW-1:0] addr;
    logic [DATAW-1:0]      wdata;
    logic [STRBW-1:0]      wstrb;
    logic [DATAW-1:0]      rdata;    // valid one cycle after re

    modport master (
        output re, we, addr, wdata, wstrb,
        input  rdata
    );

    modport slave (
        input  re, we, addr, wdata, wstrb,
        output rdata
    );

endinterface

//--- source/req_capture.sv
`timescale 1ns/10ps

module req_capture
    import dbus_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [NCORES-1:0]            re_packed_i,
    input  logic [NCORES-1:0]            we_packed_i,
    input  logic [NCORES*DMEM_ADDRW-1:0] addr_packed_i,
    input  logic [NCORES*DATAW-1:0]      wdata_packed_i,
    input  logic [NCORES*STRBW-1:0]      wstrb_packed_i,
    input  logic [NCORES-1:0]            is_lr_packed_i,
    input  logic [NCORES-1:0]            is_sc_packed_i,
    output logic [NCORES-1:0]            stall_packed_o,
    pending_if.capture                   pend
);
    logic [NCORES-1:0] req;
    logic [NCORES-1:0] load;

    assign req  = re_packed_i | we_packed_i;
    assign load = req & ~pend.valid;    // full slot ignores new strobes

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend.valid     <= '0;
            stall_packed_o <= '0;
        end else begin
            stall_packed_o <= req | pend.valid;
            for (int c = 0; c < NCORES; c++) begin
                if (load[c]) begin
                    pend.valid[c] <= 1'b1;
                end else if (pend.served && pend.served_core == CORE_IDW'(c)) begin
                    pend.valid[c] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int c = 0; c < NCORES; c++) begin
            if (load[c]) begin
                pend.re[c]    <= re_packed_i[c];
                pend.we[c]    <= we_packed_i[c];
                pend.lr[c]    <= is_lr_packed_i[c];
                pend.sc[c]    <= is_sc_packed_i[c];
                pend.addr[c]  <= addr_packed_i[c*DMEM_ADDRW +: DMEM_ADDRW];
                pend.wdata[c] <= wdata_packed_i[c*DATAW +: DATAW];
                pend.wstrb[c] <= wstrb_packed_i[c*STRBW +: STRBW];
            end
        end
    end

endmodule

//--- source/issue_lane.sv
`timescale 1ns/10ps

module issue_lane
    import dbus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [NCORES-1:0]     sc_success_i,
    pending_if.lane               pend,
    mem_port_if.master            mem,
    output logic                  chk_valid_o,
    output logic [CORE_IDW-1:0]   chk_core_o,
    output logic [DMEM_ADDRW-1:0] chk_addr_o,
    output logic                  chk_lr_o,
    output logic                  chk_sc_o,
    output logic                  chk_store_o,
    output logic                  ret_valid_o,
    output logic [CORE_IDW-1:0]   ret_core_o,
    output logic                  ret_sc_o
);
    logic [1:0]            state_q;
    logic [CORE_IDW-1:0]   rr_ptr_q;
    logic [CORE_IDW-1:0]   sel_core_q;
    logic [DMEM_ADDRW-1:0] sel_addr_q;

    logic                  pick_valid;
    logic [CORE_IDW-1:0]   pick_core;
    logic                  pick_plain_load;
    logic                  in_rsv;
    logic                  in_access;
    logic                  sel_re;
    logic                  sel_we;
    logic                  sel_sc;

    // first pending slot at or after the pointer
    always_comb begin : rr_scan
        logic [CORE_IDW-1:0] idx;
        pick_valid = 1'b0;
        pick_core  = rr_ptr_q;
        for (int n = 0; n < NCORES; n++) begin
            idx = rr_ptr_q + CORE_IDW'(n);    // wraps at NCORES
            if (!pick_valid && pend.valid[idx]) begin
                pick_valid = 1'b1;
                pick_core  = idx;
            end
        end
    end

    assign pick_plain_load = pend.re[pick_core] && !pend.lr[pick_core];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= LANE_IDLE;
            rr_ptr_q <= '0;
        end else begin
            case (state_q)
                LANE_IDLE: begin
                    if (pick_valid) begin
                        state_q <= pick_plain_load ? LANE_ACCESS : LANE_RSVCHECK;
                    end
                end
                LANE_RSVCHECK: state_q <= LANE_ACCESS;
                LANE_ACCESS: begin
                    state_q  <= LANE_IDLE;
                    rr_ptr_q <= sel_core_q + CORE_IDW'(1);
                end
                default: state_q <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == LANE_IDLE && pick_valid) begin
            sel_core_q <= pick_core;
            sel_addr_q <= pend.addr[pick_core];
        end
    end

    assign in_rsv    = (state_q == LANE_RSVCHECK);
    assign in_access = (state_q == LANE_ACCESS);
    assign sel_re    = pend.re[sel_core_q];
    assign sel_we    = pend.we[sel_core_q];
    assign sel_sc    = pend.sc[sel_core_q];

    assign chk_valid_o = in_rsv;
    assign chk_core_o  = sel_core_q;
    assign chk_addr_o  = sel_addr_q;
    assign chk_lr_o    = sel_re && pend.lr[sel_core_q];
    assign chk_sc_o    = sel_we && sel_sc;
    assign chk_store_o = sel_we && !sel_sc;

    // failed SC leaves memory untouched
    assign mem.re    = in_access && sel_re;
    assign mem.we    = in_access && sel_we && (!sel_sc || sc_success_i[sel_core_q]);
    assign mem.addr  = sel_addr_q;
    assign mem.wdata = pend.wdata[sel_core_q];
    assign mem.wstrb = pend.wstrb[sel_core_q];

    assign pend.served      = in_access;
    assign pend.served_core = sel_core_q;

    assign ret_valid_o = in_access;
    assign ret_core_o  = sel_core_q;
    assign ret_sc_o    = sel_sc;

endmodule

//--- source/reservation_table.sv
`timescale 1ns/10ps

module reservation_table
    import dbus_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  chk_valid_i,
    input  logic [CORE_IDW-1:0]   chk_core_i,
    input  logic [DMEM_ADDRW-1:0] chk_addr_i,
    input  logic                  chk_lr_i,
    input  logic                  chk_sc_i,
    input  logic                  chk_store_i,
    input  logic                  clr_valid_i,
    input  logic [CORE_IDW-1:0]   clr_core_i,
    output logic [NCORES-1:0]     sc_success_o
);
    logic [NCORES-1:0]     rsv_valid_q;
    logic [DMEM_ADDRW-1:0] rsv_addr_q [NCORES];
    logic [NCORES-1:0]     addr_hit;
    logic                  own_match;

    always_comb begin
        for (int c = 0; c < NCORES; c++) begin
            addr_hit[c] = rsv_valid_q[c] && (rsv_addr_q[c] == chk_addr_i);
        end
    end

    assign own_match = addr_hit[chk_core_i];    // SC core holds this address

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsv_valid_q  <= '0;
            sc_success_o <= '0;
        end else begin
            if (clr_valid_i) begin
                sc_success_o[clr_core_i] <= 1'b0;
            end
            if (chk_valid_i) begin
                if (chk_lr_i) begin
                    rsv_valid_q[chk_core_i] <= 1'b1;
                end else if (chk_sc_i) begin
                    sc_success_o[chk_core_i] <= own_match;
                    if (own_match) begin
                        rsv_valid_q <= rsv_valid_q & ~addr_hit;
                    end
                end else if (chk_store_i) begin
                    rsv_valid_q <= rsv_valid_q & ~addr_hit;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (chk_valid_i && chk_lr_i) begin
            rsv_addr_q[chk_core_i] <= chk_addr_i;
        end
    end

endmodule

//--- source/dmem_array.sv
`timescale 1ns/10ps

module dmem_array
    import dbus_pkg::*;
(
    input  logic      clk_i,
    mem_port_if.slave mem
);
    logic [DATAW-1:0] ram [DMEM_DEPTH];

    always_ff @(posedge clk_i) begin
        if (mem.we) begin
            for (int b = 0; b < STRBW; b++) begin
                if (mem.wstrb[b]) begin
                    ram[mem.addr][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                end
            end
        end
    end

    // zero unless read this cycle
    always_ff @(posedge clk_i) begin
        if (mem.re) begin
            mem.rdata <= ram[mem.addr];
        end else begin
            mem.rdata <= '0;
        end
    end

endmodule

//--- source/resp_return.sv
`timescale 1ns/10ps

module resp_return
    import dbus_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ret_valid_i,
    input  logic [CORE_IDW-1:0]     ret_core_i,
    input  logic                    ret_sc_i,
    input  logic [DATAW-1:0]        mem_rdata_i,
    input  logic [NCORES-1:0]       sc_success_i,
    output logic [NCORES*DATAW-1:0] rdata_packed_o,
    output logic                    clr_valid_o,
    output logic [CORE_IDW-1:0]     clr_core_o
);
    logic                ret_valid_q;
    logic [CORE_IDW-1:0] ret_core_q;
    logic                ret_sc_q;
    logic [DATAW-1:0]    result;

    // aligned with the memory read word
    always_ff @(posedge clk_i) begin
        ret_core_q <= ret_core_i;
        ret_sc_q   <= ret_sc_i;
    end

    assign result = ret_sc_q ? (sc_success_i[ret_core_q] ? SC_OK : SC_FAIL) : mem_rdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ret_valid_q    <= 1'b0;
            rdata_packed_o <= '0;
        end else begin
            ret_valid_q <= ret_valid_i;
            for (int c = 0; c < NCORES; c++) begin
                rdata_packed_o[c*DATAW +: DATAW] <=
                    (ret_valid_q && ret_core_q == CORE_IDW'(c)) ? result : '0;
            end
        end
    end

    assign clr_valid_o = ret_valid_q;    // flag read above, drop it now
    assign clr_core_o  = ret_core_q;

endmodule

//--- source/dbus_dmem.sv
`timescale 1ns/10ps

module dbus_dmem
    import dbus_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [NCORES-1:0]            re_packed_i,
    input  logic [NCORES-1:0]            we_packed_i,
    input  logic [NCORES*DMEM_ADDRW-1:0] addr_packed_i,
    input  logic [NCORES*DATAW-1:0]      wdata_packed_i,
    input  logic [NCORES*STRBW-1:0]      wstrb_packed_i,
    input  logic [NCORES-1:0]            is_lr_packed_i,
    input  logic [NCORES-1:0]            is_sc_packed_i,
    output logic [NCORES*DATAW-1:0]      rdata_packed_o,
    output logic [NCORES-1:0]            stall_packed_o
);
    logic [NCORES-1:0]     sc_success;
    logic                  chk_valid;
    logic [CORE_IDW-1:0]   chk_core;
    logic [DMEM_ADDRW-1:0] chk_addr;
    logic                  chk_lr;
    logic                  chk_sc;
    logic                  chk_store;
    logic                  ret_valid;
    logic [CORE_IDW-1:0]   ret_core;
    logic                  ret_sc;
    logic                  clr_valid;
    logic [CORE_IDW-1:0]   clr_core;

    pending_if  pend_bus ();
    mem_port_if mem_bus ();

    req_capture u_req_capture (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .re_packed_i    (re_packed_i),
        .we_packed_i    (we_packed_i),
        .addr_packed_i  (addr_packed_i),
        .wdata_packed_i (wdata_packed_i),
        .wstrb_packed_i (wstrb_packed_i),
        .is_lr_packed_i (is_lr_packed_i),
        .is_sc_packed_i (is_sc_packed_i),
        .stall_packed_o (stall_packed_o),
        .pend           (pend_bus.capture)
    );

    issue_lane u_issue_lane (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .sc_success_i (sc_success),
        .pend         (pend_bus.lane),
        .mem          (mem_bus.master),
        .chk_valid_o  (chk_valid),
        .chk_core_o   (chk_core),
        .chk_addr_o   (chk_addr),
        .chk_lr_o     (chk_lr),
        .chk_sc_o     (chk_sc),
        .chk_store_o  (chk_store),
        .ret_valid_o  (ret_valid),
        .ret_core_o   (ret_core),
        .ret_sc_o     (ret_sc)
    );

    reservation_table u_reservation_table (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .chk_valid_i  (chk_valid),
        .chk_core_i   (chk_core),
        .chk_addr_i   (chk_addr),
        .chk_lr_i     (chk_lr),
        .chk_sc_i     (chk_sc),
        .chk_store_i  (chk_store),
        .clr_valid_i  (clr_valid),
        .clr_core_i   (clr_core),
        .sc_success_o (sc_success)
    );

    dmem_array u_dmem_array (
        .clk_i (clk_i),
        .mem   (mem_bus.slave)
    );

    resp_return u_resp_return (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ret_valid_i    (ret_valid),
        .ret_core_i     (ret_core),
        .ret_sc_i       (ret_sc),
        .mem_rdata_i    (mem_bus.rdata),
        .sc_success_i   (sc_success),
        .rdata_packed_o (rdata_packed_o),
        .clr_valid_o    (clr_valid),
        .clr_core_o     (clr_core)
    );

endmodule

//--- verification/dbus_checker.sv
`timescale 1ns/10ps

module dbus_checker
    import dbus_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [NCORES-1:0]            re_i,
    input  logic [NCORES-1:0]            we_i,
    input  logic [NCORES*DMEM_ADDRW-1:0] addr_i,
    input  logic [NCORES*DATAW-1:0]      wdata_i,
    input  logic [NCORES*STRBW-1:0]      wstrb_i,
    input  logic [NCORES-1:0]            lr_i,
    input  logic [NCORES-1:0]            sc_i,
    input  logic [NCORES*DATAW-1:0]      rdata_i,
    input  logic [NCORES-1:0]            stall_i,
    input  logic                         fixed_i,      // table value checked too
    input  logic [DATAW-1:0]             fixed_val_i,
    input  logic                         test_end_i,
    input  int                           test_id_i,
    output int                           errors_o,
    output int                           failed_o
);
    logic [DATAW-1:0]      ref_mem [DMEM_DEPTH];
    logic [DMEM_ADDRW-1:0] rsv_addr [NCORES];
    logic [DATAW-1:0]      exp_q [NCORES];
    logic [DATAW-1:0]      want_q [NCORES];
    logic [NCORES-1:0]     want_on;
    logic [NCORES-1:0]     rsv_valid;
    logic [NCORES-1:0]     busy;
    logic [NCORES-1:0]     req_q;
    logic [NCORES-1:0]     stall_q;
    int                    err_mark;

    initial begin
        errors_o = 0;
        failed_o = 0;
        err_mark = 0;
    end

    task automatic report_mismatch(input string sig, input int c,
                                   input logic [DATAW-1:0] want, input logic [DATAW-1:0] got);
        errors_o++;
        $display("error at %0t ns: %s[%0d] expected %h, got %h", $time, sig, c, want, got);
    endtask

    // effects applied in request order, results kept until stall falls
    task automatic apply_request(input int c);
        logic [DMEM_ADDRW-1:0] a;
        logic [DATAW-1:0]      d;
        logic [STRBW-1:0]      s;
        logic [DATAW-1:0]      result;
        a      = addr_i[c*DMEM_ADDRW +: DMEM_ADDRW];
        d      = wdata_i[c*DATAW +: DATAW];
        s      = wstrb_i[c*STRBW +: STRBW];
        result = '0;
        if (re_i[c]) begin
            result = ref_mem[a];
            if (lr_i[c]) begin
                rsv_valid[c] = 1'b1;
                rsv_addr[c]  = a;
            end
        end else if (!sc_i[c] || (rsv_valid[c] && rsv_addr[c] == a)) begin
            result = sc_i[c] ? SC_OK : '0;
            for (int b = 0; b < STRBW; b++) begin
                if (s[b]) begin
                    ref_mem[a][b*8 +: 8] = d[b*8 +: 8];
                end
            end
            for (int k = 0; k < NCORES; k++) begin
                if (rsv_addr[k] == a) begin
                    rsv_valid[k] = 1'b0;    // any write kills reservations here
                end
            end
        end else begin
            result = SC_FAIL;
        end
        exp_q[c]   = result;
        want_on[c] = fixed_i;
        want_q[c]  = fixed_val_i;
    endtask

    always @(negedge clk_i) begin : watch
        logic [DATAW-1:0] got;
        if (!rst_n_i) begin
            rsv_valid = '0;
            busy      = '0;
            req_q     = '0;
            stall_q   = '0;
            want_on   = '0;
        end else begin
            for (int c = 0; c < NCORES; c++) begin
                got = rdata_i[c*DATAW +: DATAW];
                if (req_q[c] && stall_i[c] !== 1'b1) begin
                    report_mismatch("stall_packed_o", c, 1, stall_i[c]);
                end else if (!busy[c] && stall_i[c] !== 1'b0) begin
                    report_mismatch("stall_packed_o", c, 0, stall_i[c]);
                end
                if (busy[c] && stall_q[c] && !stall_i[c]) begin    // first cycle after the fall
                    busy[c] = 1'b0;
                    if (got !== exp_q[c]) begin
                        report_mismatch("rdata_packed_o", c, exp_q[c], got);
                    end else if (want_on[c] && got !== want_q[c]) begin
                        report_mismatch("rdata_packed_o", c, want_q[c], got);
                    end
                end else if (got !== '0) begin
                    report_mismatch("rdata_packed_o", c, '0, got);
                end
                if ((re_i[c] || we_i[c]) && !busy[c]) begin
                    busy[c] = 1'b1;
                    apply_request(c);
                end
            end
            req_q   = re_i | we_i;
            stall_q = stall_i;
            if (test_end_i) begin
                if (errors_o == err_mark) begin
                    $display("test %0d done: ok", test_id_i);
                end else begin
                    failed_o++;
                    $display("test %0d done: %0d mismatches", test_id_i, errors_o - err_mark);
                end
                err_mark = errors_o;
            end
        end
    end

endmodule

//--- verification/tb_dbus_dmem.sv
`timescale 1ns/10ps

module tb_dbus_dmem
    import dbus_pkg::*;
();
    localparam logic [1:0] OP_LD   = 2'd0;
    localparam logic [1:0] OP_ST   = 2'd1;
    localparam logic [1:0] OP_LR   = 2'd2;
    localparam logic [1:0] OP_SC   = 2'd3;
    localparam int         TIMEOUT = 40;

    typedef struct packed {
        logic [7:0]            id;
        logic [NCORES-1:0]     mask;
        logic [1:0]            op;
        logic [DMEM_ADDRW-1:0] addr;     // each core adds its index when several go at once
        logic [DATAW-1:0]      data;
        logic [STRBW-1:0]      strb;
        logic [DATAW-1:0]      want;
        logic                  fixed;    // want is the expected result
        logic                  rnd;      // data from the lfsr
    } step_t;

    step_t                        tbl [0:31];
    int                           n_steps;
    logic                         clk;
    logic                         rst_n;
    logic [NCORES-1:0]            re;
    logic [NCORES-1:0]            we;
    logic [NCORES-1:0]            lr;
    logic [NCORES-1:0]            sc;
    logic [NCORES-1:0]            stall;
    logic [NCORES*DMEM_ADDRW-1:0] addr;
    logic [NCORES*DATAW-1:0]      wdata;
    logic [NCORES*DATAW-1:0]      rdata;
    logic [NCORES*STRBW-1:0]      wstrb;
    logic                         fixed;
    logic [DATAW-1:0]             fixed_val;
    logic                         test_end;
    int                           test_id;
    logic [15:0]                  lfsr;
    int                           errors;
    int                           failed;
    int                           timeouts;
    int                           tests;

    dbus_dmem UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .re_packed_i    (re),
        .we_packed_i    (we),
        .addr_packed_i  (addr),
        .wdata_packed_i (wdata),
        .wstrb_packed_i (wstrb),
        .is_lr_packed_i (lr),
        .is_sc_packed_i (sc),
        .rdata_packed_o (rdata),
        .stall_packed_o (stall)
    );

    dbus_checker u_checker (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .re_i        (re),
        .we_i        (we),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .wstrb_i     (wstrb),
        .lr_i        (lr),
        .sc_i        (sc),
        .rdata_i     (rdata),
        .stall_i     (stall),
        .fixed_i     (fixed),
        .fixed_val_i (fixed_val),
        .test_end_i  (test_end),
        .test_id_i   (test_id),
        .errors_o    (errors),
        .failed_o    (failed)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_random(output logic [DATAW-1:0] word);
        word = '0;
        for (int b = 0; b < DATAW; b++) begin
            word = {word[DATAW-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic add_step(input logic [7:0] id, input logic [NCORES-1:0] mask,
                            input logic [1:0] op, input logic [DMEM_ADDRW-1:0] a,
                            input logic [DATAW-1:0] data, input logic [STRBW-1:0] strb,
                            input logic [DATAW-1:0] want, input logic fx, input logic rnd);
        tbl[n_steps] = {id, mask, op, a, data, strb, want, fx, rnd};
        n_steps++;
    endtask

    task automatic fill_table();
        n_steps = 0;
        // id  mask     op     addr   data          strb     want          fixed rnd
        add_step(1, 4'b0100, OP_ST, 'h010, 32'hA5A5_5A5A, 4'hF, 32'h0, 1'b1, 1'b0);
        add_step(1, 4'b0100, OP_LD, 'h010, 32'h0, 4'h0, 32'hA5A5_5A5A, 1'b1, 1'b0);
        add_step(2, 4'b0010, OP_ST, 'h020, 32'h1122_3344, 4'hF, 32'h0, 1'b1, 1'b0);
        add_step(2, 4'b0010, OP_ST, 'h020, 32'hAABB_CCDD, 4'b0101, 32'h0, 1'b1, 1'b0);
        add_step(2, 4'b0010, OP_LD, 'h020, 32'h0, 4'h0, 32'h11BB_33DD, 1'b1, 1'b0);
        add_step(3, 4'b1111, OP_ST, 'h100, 32'h0, 4'hF, 32'h0, 1'b1, 1'b1);
        add_step(3, 4'b1111, OP_LD, 'h100, 32'h0, 4'h0, 32'h0, 1'b0, 1'b0);
        add_step(4, 4'b1000, OP_ST, 'h040, 32'h0BAD_F00D, 4'hF, 32'h0, 1'b1, 1'b0);
        add_step(4, 4'b1000, OP_LR, 'h040, 32'h0, 4'h0, 32'h0BAD_F00D, 1'b1, 1'b0);
        add_step(4, 4'b1000, OP_SC, 'h040, 32'hCAFE_0001, 4'hF, SC_OK, 1'b1, 1'b0);
        add_step(4, 4'b1000, OP_LD, 'h040, 32'h0, 4'h0, 32'hCAFE_0001, 1'b1, 1'b0);
        add_step(5, 4'b0001, OP_ST, 'h050, 32'h0101_0101, 4'hF, 32'h0, 1'b1, 1'b0);
        add_step(5, 4'b0001, OP_LR, 'h050, 32'h0, 4'h0, 32'h0101_0101, 1'b1, 1'b0);
        add_step(5, 4'b0010, OP_ST, 'h050, 32'h2222_2222, 4'hF, 32'h0, 1'b1, 1'b0);
        add_step(5, 4'b0001, OP_SC, 'h050, 32'h3333_3333, 4'hF, SC_FAIL, 1'b1, 1'b0);
        add_step(5, 4'b0001, OP_LD, 'h050, 32'h0, 4'h0, 32'h2222_2222, 1'b1, 1'b0);
        add_step(6, 4'b0100, OP_ST, 'h060, 32'h6060_6060, 4'hF, 32'h0, 1'b1, 1'b0);
        add_step(6, 4'b0100, OP_SC, 'h060, 32'hFFFF_FFFF, 4'hF, SC_FAIL, 1'b1, 1'b0);
        add_step(6, 4'b0100, OP_LD, 'h060, 32'h0, 4'h0, 32'h6060_6060, 1'b1, 1'b0);
    endtask

    // one-cycle request strobe on every core in the mask
    task automatic drive_step(input step_t s);
        logic [DATAW-1:0] d;
        logic             spread;
        spread = (s.mask & (s.mask - 1'b1)) != '0;
        for (int c = 0; c < NCORES; c++) begin
            if (s.mask[c]) begin
                d = s.data;
                if (s.rnd) begin
                    take_random(d);
                end
                re[c] = (s.op == OP_LD || s.op == OP_LR);
                we[c] = (s.op == OP_ST || s.op == OP_SC);
                lr[c] = (s.op == OP_LR);
                sc[c] = (s.op == OP_SC);
                addr[c*DMEM_ADDRW +: DMEM_ADDRW] = s.addr + (spread ? c : 0);
                wdata[c*DATAW +: DATAW]          = d;
                wstrb[c*STRBW +: STRBW]          = s.strb;
            end
        end
        fixed     = s.fixed;
        fixed_val = s.want;
        @(posedge clk);
        #2;
        re       = '0;
        we       = '0;
        lr       = '0;
        sc       = '0;
        fixed    = 1'b0;
        test_end = 1'b0;
    endtask

    task automatic wait_stall(input logic [NCORES-1:0] mask, input logic level);
        logic [NCORES-1:0] target;
        int                n;
        target = level ? mask : '0;
        n      = 0;
        while ((stall & mask) != target && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if ((stall & mask) != target) begin
            timeouts++;
            $display("timeout at %0t ns: stall of cores %b never went %s", $time, mask,
                     level ? "high" : "low");
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        re        = '0;
        we        = '0;
        lr        = '0;
        sc        = '0;
        addr      = '0;
        wdata     = '0;
        wstrb     = '0;
        fixed     = 1'b0;
        fixed_val = '0;
        test_end  = 1'b0;
        test_id   = 0;
        lfsr      = 16'd58;
        timeouts  = 0;
        tests     = 0;
        fill_table();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        for (int i = 0; i < n_steps; i++) begin
            drive_step(tbl[i]);
            wait_stall(tbl[i].mask, 1'b1);
            wait_stall(tbl[i].mask, 1'b0);
            test_id  = tbl[i].id;
            test_end = (i == n_steps - 1) || (tbl[i+1].id != tbl[i].id);
            if (test_end) begin
                tests++;
            end
        end
        @(posedge clk);
        #2;
        test_end = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        $display("tests %0d, failed %0d, mismatches %0d, timeouts %0d",
                 tests, failed, errors, timeouts);
        if (errors == 0 && failed == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- src.f
source/dbus_pkg.sv
source/pending_if.sv
source/mem_port_if.sv
source/req_capture.sv
source/issue_lane.sv
source/reservation_table.sv
source/dmem_array.sv
source/resp_return.sv
source/dbus_dmem.sv
verification/dbus_checker.sv
verification/tb_dbus_dmem.sv
